// File: design/ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Lane count, any value of 2 or more
`define EX_LANES 4

// Width of a lane index
`define EX_LANE_BITS $clog2(`EX_LANES)

// Iterations of the shift-add multiplier, one per multiplier bit
`define EX_MUL_STEPS 32

`endif

// File: design/ex_op_pkg.sv
package ex_op_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_NOR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

	// High word variants take signed or unsigned operands
	typedef enum logic [1:0] {
		MUL_NONE,
		MUL_W,
		MULH_W,
		MULH_WU
	} mul_op_t;

	typedef enum logic [3:0] {
		MEM_NONE,
		LD_B,
		LD_H,
		LD_W,
		LD_BU,
		LD_HU,
		ST_B,
		ST_H,
		ST_W
	} mem_op_t;

endpackage

// File: design/ex_trap_pkg.sv
package ex_trap_pkg;

	typedef logic [5:0] ecode_t;
	typedef logic [8:0] esubcode_t;

	// Address alignment error
	localparam ecode_t ECODE_ALE = 6'h9;

	localparam esubcode_t ESUBCODE_NONE = 9'h0;

endpackage

// File: design/ex_alu.sv
module ex_alu
	import ex_op_pkg::*;
(
	input alu_op_t alu_op,
	input word_t src1,
	input word_t src2,
	output word_t result
);

	logic [4:0] shamt;

	assign shamt = src2[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD: begin
				result = src1 + src2;
			end
			ALU_SUB: begin
				result = src1 - src2;
			end
			ALU_SLT: begin
				result = {31'b0, $signed(src1) < $signed(src2)};
			end
			ALU_SLTU: begin
				result = {31'b0, src1 < src2};
			end
			ALU_AND: begin
				result = src1 & src2;
			end
			ALU_OR: begin
				result = src1 | src2;
			end
			ALU_NOR: begin
				result = ~(src1 | src2);
			end
			ALU_XOR: begin
				result = src1 ^ src2;
			end
			ALU_SLL: begin
				result = src1 << shamt;
			end
			ALU_SRL: begin
				result = src1 >> shamt;
			end
			ALU_SRA: begin
				result = word_t'($signed(src1) >>> shamt);
			end
			// Immediate already shifted by decode
			ALU_LUI: begin
				result = src2;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: design/ex_lane.sv
`include "ex_params.svh"

module ex_lane
	import ex_op_pkg::*;
	import ex_trap_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic start,
	output logic idle,
	input logic released,
	output logic done,

	input word_t pc,
	input word_t imm,
	input word_t rj_value,
	input word_t rkd_value,
	input alu_op_t alu_op,
	input mul_op_t mul_op,
	input mem_op_t mem_op,
	input logic src1_is_pc,
	input logic src2_is_imm,
	input logic gr_we,
	input logic has_exception,
	input reg_idx_t dest,
	input ecode_t ecode,
	input esubcode_t esubcode,

	output word_t res_pc,
	output word_t res_result,
	output word_t res_badv,
	output word_t res_store_data,
	output reg_idx_t res_dest,
	output logic res_gr_we,
	output mem_op_t res_mem_op,
	output logic res_has_exception,
	output ecode_t res_ecode,
	output esubcode_t res_esubcode
);

	typedef enum logic [1:0] {ST_IDLE, ST_MULT, ST_DONE} state_t;

	localparam int CNT_W = $clog2(`EX_MUL_STEPS);

	state_t state;
	logic [CNT_W-1:0] step;
	word_t src1;
	word_t src2;
	word_t alu_result;
	word_t addr;
	logic ale;
	logic take_exc;
	logic last_step;
	logic mul_signed;
	logic mul_hi;
	logic [63:0] mcand;
	logic [63:0] prod;
	logic [63:0] prod_next;
	word_t mplier;

	assign src1 = src1_is_pc ? pc : rj_value;
	assign src2 = src2_is_imm ? imm : rkd_value;

	ex_alu u_alu (
		.alu_op (alu_op),
		.src1   (src1),
		.src2   (src2),
		.result (alu_result)
	);

	assign addr = src1 + src2;

	always_comb begin
		case (mem_op)
			LD_H, LD_HU, ST_H: ale = addr[0];
			LD_W, ST_W: ale = addr[1:0] != 2'b00;
			default: ale = 1'b0;
		endcase
	end

	assign take_exc = has_exception | ale;
	assign idle = state == ST_IDLE;
	assign done = state == ST_DONE;
	assign last_step = step == CNT_W'(`EX_MUL_STEPS - 1);

	// Top multiplier bit weighs -2^31 when signed
	always_comb begin
		prod_next = prod;
		if (mplier[0]) begin
			prod_next = (last_step && mul_signed) ? prod - mcand : prod + mcand;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= ST_IDLE;
			step <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					step <= '0;
					if (start) begin
						state <= (mul_op != MUL_NONE && !take_exc) ? ST_MULT : ST_DONE;
					end
				end
				ST_MULT: begin
					if (last_step) begin
						state <= ST_DONE;
					end else begin
						step <= step + 1'b1;
					end
				end
				ST_DONE: begin
					if (released) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			res_pc <= pc;
			res_result <= alu_result;
			res_badv <= addr;
			res_store_data <= rkd_value;
			res_dest <= dest;
			res_gr_we <= gr_we;
			res_mem_op <= mem_op;
			res_has_exception <= take_exc;
			// Earlier stage exception outranks ALE
			if (has_exception) begin
				res_ecode <= ecode;
				res_esubcode <= esubcode;
			end else if (ale) begin
				res_ecode <= ECODE_ALE;
				res_esubcode <= ESUBCODE_NONE;
			end else begin
				res_ecode <= '0;
				res_esubcode <= ESUBCODE_NONE;
			end
			mul_signed <= mul_op != MULH_WU;
			mul_hi <= mul_op != MUL_W;
			mcand <= (mul_op == MULH_WU) ? {32'b0, src1} : {{32{src1[31]}}, src1};
			mplier <= src2;
			prod <= '0;
		end else if (state == ST_MULT) begin
			prod <= prod_next;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
			if (last_step) begin
				res_result <= mul_hi ? prod_next[63:32] : prod_next[31:0];
			end
		end
	end

endmodule

// File: design/ex_dispatch.sv
`include "ex_params.svh"

module ex_dispatch (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic valid,
	output logic ready,
	input logic [`EX_LANES-1:0] lane_idle,
	output logic [`EX_LANES-1:0] lane_start
);

	logic [`EX_LANE_BITS-1:0] ptr;
	logic accept;

	// Only the lane under the pointer may take the next instruction
	assign ready = ~rst & ~flush & lane_idle[ptr];
	assign accept = valid & ready;

	always_comb begin
		lane_start = '0;
		if (accept) begin
			lane_start[ptr] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ptr <= '0;
		end else if (accept) begin
			if (ptr == `EX_LANE_BITS'(`EX_LANES - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

endmodule

// File: design/ex_retire.sv
`include "ex_params.svh"

module ex_retire
	import ex_op_pkg::*;
	import ex_trap_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic [`EX_LANES-1:0] lane_done,
	output logic [`EX_LANES-1:0] lane_release,
	output logic wb_valid,
	input logic wb_ready,

	input word_t lane_pc [`EX_LANES],
	input word_t lane_result [`EX_LANES],
	input word_t lane_badv [`EX_LANES],
	input word_t lane_store_data [`EX_LANES],
	input reg_idx_t lane_dest [`EX_LANES],
	input logic lane_gr_we [`EX_LANES],
	input mem_op_t lane_mem_op [`EX_LANES],
	input logic lane_has_exception [`EX_LANES],
	input ecode_t lane_ecode [`EX_LANES],
	input esubcode_t lane_esubcode [`EX_LANES],

	output word_t wb_pc,
	output word_t wb_result,
	output reg_idx_t wb_dest,
	output logic wb_gr_we,
	output mem_op_t wb_mem_op,
	output word_t wb_store_data,
	output logic wb_has_exception,
	output ecode_t wb_ecode,
	output esubcode_t wb_esubcode,
	output word_t wb_badv
);

	logic [`EX_LANE_BITS-1:0] ptr;
	logic handshake;

	// Head lane is the oldest instruction
	assign wb_valid = lane_done[ptr] & ~flush;
	assign handshake = wb_valid & wb_ready;

	assign wb_pc = lane_pc[ptr];
	assign wb_result = lane_result[ptr];
	assign wb_dest = lane_dest[ptr];
	assign wb_gr_we = lane_gr_we[ptr];
	assign wb_mem_op = lane_mem_op[ptr];
	assign wb_store_data = lane_store_data[ptr];
	assign wb_has_exception = lane_has_exception[ptr];
	assign wb_ecode = lane_ecode[ptr];
	assign wb_esubcode = lane_esubcode[ptr];
	assign wb_badv = lane_badv[ptr];

	always_comb begin
		lane_release = '0;
		if (handshake) begin
			lane_release[ptr] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ptr <= '0;
		end else if (handshake) begin
			if (ptr == `EX_LANE_BITS'(`EX_LANES - 1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + 1'b1;
			end
		end
	end

endmodule

// File: design/ex_cluster.sv
`include "ex_params.svh"

module ex_cluster
	import ex_op_pkg::*;
	import ex_trap_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,

	input logic valid,
	output logic ready,
	input word_t pc,
	input alu_op_t alu_op,
	input mul_op_t mul_op,
	input logic src1_is_pc,
	input logic src2_is_imm,
	input word_t imm,
	input word_t rj_value,
	input word_t rkd_value,
	input reg_idx_t dest,
	input logic gr_we,
	input mem_op_t mem_op,
	input logic has_exception,
	input ecode_t ecode,
	input esubcode_t esubcode,

	output logic wb_valid,
	input logic wb_ready,
	output word_t wb_pc,
	output word_t wb_result,
	output reg_idx_t wb_dest,
	output logic wb_gr_we,
	output mem_op_t wb_mem_op,
	output word_t wb_store_data,
	output logic wb_has_exception,
	output ecode_t wb_ecode,
	output esubcode_t wb_esubcode,
	output word_t wb_badv
);

	logic [`EX_LANES-1:0] lane_idle;
	logic [`EX_LANES-1:0] lane_start;
	logic [`EX_LANES-1:0] lane_done;
	logic [`EX_LANES-1:0] lane_release;

	word_t lane_pc [`EX_LANES];
	word_t lane_result [`EX_LANES];
	word_t lane_badv [`EX_LANES];
	word_t lane_store_data [`EX_LANES];
	reg_idx_t lane_dest [`EX_LANES];
	logic lane_gr_we [`EX_LANES];
	mem_op_t lane_mem_op [`EX_LANES];
	logic lane_has_exception [`EX_LANES];
	ecode_t lane_ecode [`EX_LANES];
	esubcode_t lane_esubcode [`EX_LANES];

	ex_dispatch u_dispatch (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.valid      (valid),
		.ready      (ready),
		.lane_idle  (lane_idle),
		.lane_start (lane_start)
	);

	// Payload goes to every lane, start picks the one that latches it
	for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
		ex_lane u_lane (
			.clk               (clk),
			.rst               (rst),
			.flush             (flush),
			.start             (lane_start[i]),
			.idle              (lane_idle[i]),
			.released          (lane_release[i]),
			.done              (lane_done[i]),
			.pc                (pc),
			.imm               (imm),
			.rj_value          (rj_value),
			.rkd_value         (rkd_value),
			.alu_op            (alu_op),
			.mul_op            (mul_op),
			.mem_op            (mem_op),
			.src1_is_pc        (src1_is_pc),
			.src2_is_imm       (src2_is_imm),
			.gr_we             (gr_we),
			.has_exception     (has_exception),
			.dest              (dest),
			.ecode             (ecode),
			.esubcode          (esubcode),
			.res_pc            (lane_pc[i]),
			.res_result        (lane_result[i]),
			.res_badv          (lane_badv[i]),
			.res_store_data    (lane_store_data[i]),
			.res_dest          (lane_dest[i]),
			.res_gr_we         (lane_gr_we[i]),
			.res_mem_op        (lane_mem_op[i]),
			.res_has_exception (lane_has_exception[i]),
			.res_ecode         (lane_ecode[i]),
			.res_esubcode      (lane_esubcode[i])
		);
	end

	ex_retire u_retire (
		.clk                (clk),
		.rst                (rst),
		.flush              (flush),
		.lane_done          (lane_done),
		.lane_release       (lane_release),
		.wb_valid           (wb_valid),
		.wb_ready           (wb_ready),
		.lane_pc            (lane_pc),
		.lane_result        (lane_result),
		.lane_badv          (lane_badv),
		.lane_store_data    (lane_store_data),
		.lane_dest          (lane_dest),
		.lane_gr_we         (lane_gr_we),
		.lane_mem_op        (lane_mem_op),
		.lane_has_exception (lane_has_exception),
		.lane_ecode         (lane_ecode),
		.lane_esubcode      (lane_esubcode),
		.wb_pc              (wb_pc),
		.wb_result          (wb_result),
		.wb_dest            (wb_dest),
		.wb_gr_we           (wb_gr_we),
		.wb_mem_op          (wb_mem_op),
		.wb_store_data      (wb_store_data),
		.wb_has_exception   (wb_has_exception),
		.wb_ecode           (wb_ecode),
		.wb_esubcode        (wb_esubcode),
		.wb_badv            (wb_badv)
	);

endmodule

// File: sim/ex_ref.svh
`ifndef EX_REF_SVH
`define EX_REF_SVH

// One expected writeback record
typedef struct packed {
	word_t pc;
	word_t result;
	reg_idx_t dest;
	logic gr_we;
	mem_op_t mem_op;
	word_t store_data;
	logic has_exception;
	ecode_t ecode;
	esubcode_t esubcode;
	word_t badv;
} exp_item_t;

function automatic exp_item_t ex_expect(
	input word_t pc,
	input alu_op_t alu_op,
	input mul_op_t mul_op,
	input logic src1_is_pc,
	input logic src2_is_imm,
	input word_t imm,
	input word_t rj_value,
	input word_t rkd_value,
	input reg_idx_t dest,
	input logic gr_we,
	input mem_op_t mem_op,
	input logic has_exception,
	input ecode_t ecode,
	input esubcode_t esubcode
);
	exp_item_t item;
	word_t s1;
	word_t s2;
	word_t addr;
	logic ale;
	logic signed [63:0] prod_s;
	logic [63:0] prod_u;

	s1 = src1_is_pc ? pc : rj_value;
	s2 = src2_is_imm ? imm : rkd_value;
	addr = s1 + s2;
	prod_s = $signed({{32{s1[31]}}, s1}) * $signed({{32{s2[31]}}, s2});
	prod_u = {32'b0, s1} * {32'b0, s2};

	case (alu_op)
		ALU_ADD: item.result = addr;
		ALU_SUB: item.result = s1 - s2;
		ALU_SLT: item.result = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
		ALU_SLTU: item.result = (s1 < s2) ? 32'd1 : 32'd0;
		ALU_AND: item.result = s1 & s2;
		ALU_OR: item.result = s1 | s2;
		ALU_NOR: item.result = ~(s1 | s2);
		ALU_XOR: item.result = s1 ^ s2;
		ALU_SLL: item.result = s1 << s2[4:0];
		ALU_SRL: item.result = s1 >> s2[4:0];
		ALU_SRA: item.result = word_t'($signed(s1) >>> s2[4:0]);
		ALU_LUI: item.result = s2;
		default: item.result = '0;
	endcase

	case (mem_op)
		LD_H, LD_HU, ST_H: ale = addr[0];
		LD_W, ST_W: ale = addr[1:0] != 2'b00;
		default: ale = 1'b0;
	endcase

	// Excepting instructions never reach the multiplier
	if (!has_exception && !ale) begin
		case (mul_op)
			MUL_W: item.result = prod_s[31:0];
			MULH_W: item.result = prod_s[63:32];
			MULH_WU: item.result = prod_u[63:32];
			default: ;
		endcase
	end

	item.pc = pc;
	item.dest = dest;
	item.gr_we = gr_we;
	item.mem_op = mem_op;
	item.store_data = rkd_value;
	item.badv = addr;
	item.has_exception = has_exception | ale;
	item.ecode = has_exception ? ecode : (ale ? ECODE_ALE : '0);
	item.esubcode = has_exception ? esubcode : '0;
	return item;
endfunction

`endif

// File: sim/ex_tb.sv
`include "ex_params.svh"

module ex_tb
	import ex_op_pkg::*;
	import ex_trap_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	`include "ex_ref.svh"

	localparam int ALU_LATENCY = 1;
	// Start cycle plus one cycle per multiplier bit
	localparam int MUL_LATENCY = `EX_MUL_STEPS + 1;
	localparam int N_RANDOM_ALU = 200;
	localparam int N_MIXED_MUL = 60;
	localparam int N_MEM = 80;
	localparam int N_BACKPRESSURE = 100;
	localparam int N_AFTER_FLUSH = 40;
	localparam int TOTAL_ITEMS = 3 + N_RANDOM_ALU + N_MIXED_MUL + N_MEM + N_BACKPRESSURE
		+ N_AFTER_FLUSH + 2 * `EX_LANES;
	localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 40 + 2000;

	logic clk;
	logic rst;
	logic flush;
	logic valid;
	logic ready;
	word_t pc;
	alu_op_t alu_op;
	mul_op_t mul_op;
	logic src1_is_pc;
	logic src2_is_imm;
	word_t imm;
	word_t rj_value;
	word_t rkd_value;
	reg_idx_t dest;
	logic gr_we;
	mem_op_t mem_op;
	logic has_exception;
	ecode_t ecode;
	esubcode_t esubcode;
	logic wb_valid;
	logic wb_ready;
	word_t wb_pc;
	word_t wb_result;
	reg_idx_t wb_dest;
	logic wb_gr_we;
	mem_op_t wb_mem_op;
	word_t wb_store_data;
	logic wb_has_exception;
	ecode_t wb_ecode;
	esubcode_t wb_esubcode;
	word_t wb_badv;

	exp_item_t exp_q[$];
	string cur_test;
	int bp_mode;
	int check_errors = 0;
	int stim_errors = 0;
	int accepted = 0;
	int retired = 0;
	int start_errors;
	int start_items;

	ex_cluster uut (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// 0 always ready, 1 held low, 2 random
	initial begin
		wb_ready = 1'b1;
		forever begin
			@(negedge clk);
			if (bp_mode == 2) begin
				wb_ready = 1'($urandom);
			end else begin
				wb_ready = bp_mode == 0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout in %s after %0d cycles", cur_test, WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic check_value(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s %s: expected %h, actual %h", cur_test, field, expected, actual);
			check_errors++;
		end
	endtask

	task automatic compare_item(input exp_item_t head);
		check_value("pc", head.pc, wb_pc);
		check_value("result", head.result, wb_result);
		check_value("dest", 32'(head.dest), 32'(wb_dest));
		check_value("gr_we", 32'(head.gr_we), 32'(wb_gr_we));
		check_value("mem_op", 32'(head.mem_op), 32'(wb_mem_op));
		check_value("store_data", head.store_data, wb_store_data);
		check_value("has_exception", 32'(head.has_exception), 32'(wb_has_exception));
		check_value("ecode", 32'(head.ecode), 32'(wb_ecode));
		check_value("esubcode", 32'(head.esubcode), 32'(wb_esubcode));
		check_value("badv", head.badv, wb_badv);
	endtask

	// Scoreboard and compare
	always @(posedge clk) begin
		if (flush) begin
			exp_q.delete();
		end else if (!rst) begin
			if (wb_valid && wb_ready) begin
				if (exp_q.size() == 0) begin
					$display("Error in %s: writeback of pc %h with nothing pending",
						cur_test, wb_pc);
					check_errors++;
				end else begin
					compare_item(exp_q.pop_front());
				end
				retired++;
			end
			if (valid && ready) begin
				exp_q.push_back(ex_expect(pc, alu_op, mul_op, src1_is_pc, src2_is_imm, imm,
					rj_value, rkd_value, dest, gr_we, mem_op, has_exception, ecode, esubcode));
				accepted++;
			end
		end
	end

	task automatic report_error(input string what);
		$display("Error in %s: %s", cur_test, what);
		stim_errors++;
	endtask

	// Kind 0 ALU only, 1 mixed with multiplies, 2 memory ops
	task automatic randomize_item(input int kind);
		pc = $urandom & 32'hffff_fffc;
		alu_op = alu_op_t'($urandom % 12);
		mul_op = MUL_NONE;
		mem_op = MEM_NONE;
		src1_is_pc = 1'($urandom);
		src2_is_imm = 1'($urandom);
		imm = $urandom;
		rj_value = $urandom;
		rkd_value = $urandom;
		dest = reg_idx_t'($urandom);
		gr_we = 1'($urandom);
		has_exception = 1'b0;
		ecode = '0;
		esubcode = '0;
		if (kind == 1 && ($urandom % 2) == 1) begin
			mul_op = mul_op_t'(1 + $urandom % 3);
		end
		if (kind == 2) begin
			alu_op = ALU_ADD;
			mem_op = mem_op_t'(1 + $urandom % 8);
			has_exception = ($urandom % 4) == 0;
			ecode = ecode_t'($urandom);
			esubcode = esubcode_t'($urandom);
		end
	endtask

	task automatic send_random(input int kind);
		@(negedge clk);
		randomize_item(kind);
		valid = 1'b1;
		@(posedge clk);
		while (!ready) begin
			@(posedge clk);
		end
	endtask

	task automatic drain_queue();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic finish_stream();
		@(negedge clk);
		valid = 1'b0;
		drain_queue();
	endtask

	// Inputs already set on a falling edge, cluster idle
	task automatic measure_latency(input int expected);
		int cycles;
		if (!ready) begin
			report_error("ready low on an idle cluster");
		end
		valid = 1'b1;
		@(posedge clk);
		cycles = 0;
		do begin
			@(negedge clk);
			valid = 1'b0;
			cycles++;
		end while (!wb_valid && cycles < 100);
		if (cycles != expected) begin
			$display("Fail %s latency: expected %0d, actual %0d", cur_test, expected, cycles);
			stim_errors++;
		end
		drain_queue();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		start_errors = check_errors + stim_errors;
		start_items = accepted;
	endtask

	task automatic end_test();
		$display("Test %s: %0d items, %0d errors", cur_test, accepted - start_items,
			check_errors + stim_errors - start_errors);
	endtask

	initial begin
		void'($urandom(32'h7ac92312));
		bp_mode = 0;
		cur_test = "reset";
		randomize_item(0);
		valid = 1'b0;
		flush = 1'b0;
		rst = 1'b1;
		repeat (16) @(negedge clk);
		if (ready || wb_valid) begin
			report_error("ready or wb_valid high during reset");
		end
		rst = 1'b0;

		begin_test("reset_single_alu");
		@(posedge clk);
		if (!ready || wb_valid) begin
			report_error("cluster not idle and ready after reset");
		end
		@(negedge clk);
		randomize_item(0);
		measure_latency(ALU_LATENCY);
		end_test();

		begin_test("random_alu");
		repeat (N_RANDOM_ALU) send_random(0);
		finish_stream();
		end_test();

		begin_test("mul_order");
		repeat (N_MIXED_MUL) send_random(1);
		finish_stream();
		@(negedge clk);
		randomize_item(0);
		mul_op = mul_op_t'(1 + $urandom % 3);
		measure_latency(MUL_LATENCY);
		end_test();

		begin_test("mem_align");
		repeat (N_MEM) send_random(2);
		finish_stream();
		@(negedge clk);
		randomize_item(2);
		has_exception = 1'b1;
		mul_op = MUL_W;
		measure_latency(ALU_LATENCY);
		end_test();

		begin_test("backpressure");
		@(posedge clk);
		bp_mode = 1;
		repeat (`EX_LANES) send_random(0);
		@(negedge clk);
		valid = 1'b0;
		@(posedge clk);
		if (ready) begin
			report_error("ready stayed high with every lane holding a result");
		end
		bp_mode = 2;
		repeat (N_BACKPRESSURE) send_random(1);
		finish_stream();
		@(posedge clk);
		bp_mode = 0;
		end_test();

		begin_test("flush");
		@(posedge clk);
		bp_mode = 1;
		repeat (`EX_LANES) send_random(1);
		@(negedge clk);
		valid = 1'b0;
		flush = 1'b1;
		@(posedge clk);
		if (ready || wb_valid) begin
			report_error("ready or wb_valid high during flush");
		end
		bp_mode = 0;
		@(negedge clk);
		flush = 1'b0;
		@(negedge clk);
		if (!ready || wb_valid) begin
			report_error("lanes not idle after flush");
		end
		repeat (40) @(posedge clk);
		repeat (N_AFTER_FLUSH) send_random(1);
		finish_stream();
		end_test();

		if (exp_q.size() != 0) begin
			report_error("expected results never reached writeback");
		end
		$display("Tests 6, accepted %0d, retired %0d, errors %0d", accepted, retired,
			check_errors + stim_errors);
		if (check_errors + stim_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+design
+incdir+sim
design/ex_op_pkg.sv
design/ex_trap_pkg.sv
design/ex_alu.sv
design/ex_lane.sv
design/ex_dispatch.sv
design/ex_retire.sv
design/ex_cluster.sv
sim/ex_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module ex_tb \
	--Mdir obj_dir -o ex_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ex_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
